// ==== tb_hk_cases.txt ====
# op addr data sel expected, all hex; w write, r read, c read within 2, h hsk inputs,
# s stop clock addr, t wait data cycles, o output addr (see read_output); h data bits:
# 0 tri 1 val 2 local 3 crate 5:4 conf 6 i2c 15:8 rx bytes
o 000 00000000 0 00000001
o 001 00000000 0 00000001
o 002 00000000 0 00000001
o 003 00000000 0 00000008
o 004 00000000 0 00000000
o 005 00000000 0 00000000
o 006 00000000 0 00000000
o 007 00000000 0 00000000
r 000 00000000 f 5446494f
r 004 00000000 f 01020304
r 020 00000000 f 00000000
r 070 00000000 f 00000000
w 070 12345678 f 00000000
# Register writes, full and partial
w 010 0000015a f 00000000
r 010 00000000 f 0000015a
o 003 00000000 0 0000005a
o 004 00000000 0 00000001
w 014 000000c3 f 00000000
r 014 00000000 f 000000c3
o 005 00000000 0 000000c3
w 018 ffe00000 f 00000000
r 018 00000000 f c1e00000
o 006 00000000 0 00000003
o 007 00000000 0 0000000f
w 018 00000000 4 00000000
r 018 00000000 f c1000000
o 007 00000000 0 00000008
w 010 00000000 2 00000000
r 010 00000000 f 0000005a
# Control and status
h 000 0000a56d 0 00000000
w 00c 00000000 1 00000000
o 000 00000000 0 00000000
o 001 00000000 0 00000000
o 002 00000000 0 00000000
r 00c 00000000 f 00a50270
w 00c 0000008c 1 00000000
r 00c 00000000 f 00a502fc
# Housekeeping override, then a bus write on the same edge
h 000 0000a56c 0 00000000
t 000 00000002 0 00000000
o 000 00000000 0 00000000
o 008 00000000 0 00000000
h 000 0000a56e 0 00000000
t 000 00000002 0 00000000
o 000 00000000 0 00000001
w 00c 00000088 1 00000000
o 00b 00000000 0 00000000
o 00c 00000000 0 00000000
o 000 00000000 0 00000001
h 000 0000a56d 0 00000000
# Clock monitor
t 000 00000834 0 00000000
c 040 00000000 f 00000040
c 044 00000000 f 00000066
c 048 00000000 f 00000080
c 04c 00000000 f 00000033
r 050 00000000 f 0000000f
r 05c 00000000 f 00000000
o 009 00000000 0 00000001
o 00a 00000000 0 00000001
r 00c 00000000 f 00a502ff
w 040 ffffffff f 00000000
c 040 00000000 f 00000040
s 002 00000000 0 00000000
t 000 00000834 0 00000000
r 048 00000000 f 00000000
r 050 00000000 f 0000000b
o 009 00000000 0 00000001
o 00a 00000000 0 00000000
r 00c 00000000 f 00a502fd

// ==== filelist.f ====
hk_regmap_pkg.sv
clkmon_pkg.sv
hk_bus_if.sv
hk_ctrl_regs.sv
clock_mon.sv
tio_hk_top.sv
tb_tio_hk.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the housekeeping block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f filelist.f \
    --top-module tb_tio_hk \
    -o tb_tio_hk

# The simulator exits non-zero on a fatal error, the log decides
./obj_dir/tb_tio_hk 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== tb_tio_hk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tio_hk;

    // Bus clock and reset
    logic        wb_clk_i;
    logic        wb_rst_i;
    // Wishbone master side
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [11:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    // Housekeeping inputs
    logic        hsk_en_tri_i;
    logic        hsk_en_val_i;
    logic        hsk_local_i;
    logic        hskbus_crate_i;
    logic [7:0]  hskbus_rx_bytes_i;
    logic [1:0]  crate_conf_i;
    logic        i2c_rdy_i;
    // DUT outputs
    logic        hsk_en_o;
    logic        sysclk_rst_o;
    logic        enable_crate_o;
    logic        enable_3v3_o;
    logic [7:0]  sync_offset_o;
    logic        en_ext_sync_o;
    logic [7:0]  clk_offset_o;
    logic [1:0]  burst_size_o;
    logic [3:0]  upper_addr_o;
    logic        sys_clk_ok_o;
    logic        rx_clk_ok_o;

    // Monitored clocks that freeze when their run bit is cleared
    wire  [3:0]  mon_clk;
    logic [3:0]  mon_run = 4'hf;

    // Cases as read from the file
    logic [7:0]  op_q  [$];
    logic [11:0] adr_q [$];
    logic [31:0] dat_q [$];
    logic [3:0]  sel_q [$];
    logic [31:0] exp_q [$];
    int          n_wait;
    int          n_checks;
    logic        cases_loaded = 1'b0;

    // Crate enable seen together with the last ack
    logic        crate_at_ack;
    logic        hsk_en_at_ack;

    tio_hk_top dut_i (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_sel_i          (wb_sel_i),
        .wb_ack_o          (wb_ack_o),
        .wb_dat_o          (wb_dat_o),
        .hsk_en_tri_i      (hsk_en_tri_i),
        .hsk_en_val_i      (hsk_en_val_i),
        .hsk_local_i       (hsk_local_i),
        .hskbus_crate_i    (hskbus_crate_i),
        .hskbus_rx_bytes_i (hskbus_rx_bytes_i),
        .crate_conf_i      (crate_conf_i),
        .i2c_rdy_i         (i2c_rdy_i),
        .mon_clk_i         (mon_clk),
        .hsk_en_o          (hsk_en_o),
        .sysclk_rst_o      (sysclk_rst_o),
        .enable_crate_o    (enable_crate_o),
        .enable_3v3_o      (enable_3v3_o),
        .sync_offset_o     (sync_offset_o),
        .en_ext_sync_o     (en_ext_sync_o),
        .clk_offset_o      (clk_offset_o),
        .burst_size_o      (burst_size_o),
        .upper_addr_o      (upper_addr_o),
        .sys_clk_ok_o      (sys_clk_ok_o),
        .rx_clk_ok_o       (rx_clk_ok_o)
    );

    // 8 ns bus clock
    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    // Periods of 16, 10, 8 and 20 ns shifted off the bus clock edges
    for (genvar g = 0; g < 4; g++) begin : g_mon_clk
        localparam int HALF_NS = (g == 0) ? 8 : (g == 1) ? 5 : (g == 2) ? 4 : 10;
        logic clk_q;

        initial begin
            clk_q = 1'b0;
            #0.5;
            forever begin
                #(HALF_NS);
                if (mon_run[g]) begin
                    clk_q = ~clk_q;
                end
            end
        end

        assign mon_clk[g] = clk_q;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        n_checks++;
        if (exp !== got) begin
            $display("FAIL %s exp=%h got=%h", name, exp, got);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Counts may be off by two from the nominal 1024/P
    function automatic logic [31:0] within_two(input logic [31:0] exp, input logic [31:0] got);
        int diff;
        diff = int'(got) - int'(exp);
        if (diff >= -2 && diff <= 2) begin
            return exp;
        end else begin
            return got;
        end
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        logic [7:0]  op;
        logic [11:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic [31:0] exp;
        fd = $fopen("tb_hk_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_hk_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "no cases file");
        end
        n_wait = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // Skip blank and comment lines
            if (n != 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h", op, adr, dat, sel, exp);
                if (n != 5) begin
                    $display("malformed case line: %s", line);
                    $display("TEST FAILED");
                    $fatal(1, "bad cases file");
                end
                op_q.push_back(op);
                adr_q.push_back(adr);
                dat_q.push_back(dat);
                sel_q.push_back(sel);
                exp_q.push_back(exp);
                if (op == "t") begin
                    n_wait++;
                end
            end
        end
        $fclose(fd);
        cases_loaded = 1'b1;
    endtask

    // Single classic cycle with ack expected one cycle after strobe
    task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdat);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        waited   = 0;
        do begin
            @(posedge wb_clk_i);
            #1;
            waited++;
        end while (!wb_ack_o && waited < 8);
        if (!wb_ack_o) begin
            $display("access to address 0x%03h got no ack within 8 cycles", adr);
            $display("TEST FAILED");
            $fatal(1, "bus timeout");
        end
        check("wb_ack_o latency", 32'd1, 32'(waited));
        rdat          = wb_dat_o;
        crate_at_ack  = enable_crate_o;
        hsk_en_at_ack = hsk_en_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge wb_clk_i);
        #1;
        // One-cycle pulse only
        check("wb_ack_o after ack", 32'd0, 32'(wb_ack_o));
    endtask

    // Bit layout as in the cases file header
    task automatic drive_hsk(input logic [31:0] v);
        hsk_en_tri_i      = v[0];
        hsk_en_val_i      = v[1];
        hsk_local_i       = v[2];
        hskbus_crate_i    = v[3];
        crate_conf_i      = v[5:4];
        i2c_rdy_i         = v[6];
        hskbus_rx_bytes_i = v[15:8];
    endtask

    // Signal name of each output index used by the cases file
    function automatic string output_name(input logic [11:0] idx);
        case (idx)
            12'd0:   return "enable_crate_o";
            12'd1:   return "enable_3v3_o";
            12'd2:   return "sysclk_rst_o";
            12'd3:   return "sync_offset_o";
            12'd4:   return "en_ext_sync_o";
            12'd5:   return "clk_offset_o";
            12'd6:   return "burst_size_o";
            12'd7:   return "upper_addr_o";
            12'd8:   return "hsk_en_o";
            12'd9:   return "sys_clk_ok_o";
            12'd10:  return "rx_clk_ok_o";
            12'd11:  return "enable_crate_o at ack";
            12'd12:  return "hsk_en_o at ack";
            default: return "unknown output";
        endcase
    endfunction

    task automatic read_output(input logic [11:0] idx, output string name,
                               output logic [31:0] val);
        name = output_name(idx);
        case (idx)
            12'd0:  val = 32'(enable_crate_o);
            12'd1:  val = 32'(enable_3v3_o);
            12'd2:  val = 32'(sysclk_rst_o);
            12'd3:  val = 32'(sync_offset_o);
            12'd4:  val = 32'(en_ext_sync_o);
            12'd5:  val = 32'(clk_offset_o);
            12'd6:  val = 32'(burst_size_o);
            12'd7:  val = 32'(upper_addr_o);
            12'd8:  val = 32'(hsk_en_o);
            12'd9:  val = 32'(sys_clk_ok_o);
            12'd10: val = 32'(rx_clk_ok_o);
            12'd11: val = 32'(crate_at_ack);
            12'd12: val = 32'(hsk_en_at_ack);
            default: begin
                $display("cases file names output %0d, which does not exist", idx);
                $display("TEST FAILED");
                $fatal(1, "bad output index");
            end
        endcase
    endtask

    // Bound scales with the number of wait cases
    initial begin
        int limit;
        wait (cases_loaded);
        limit = 3 * clkmon_pkg::CLKMON_WINDOW * n_wait + 2000;
        repeat (limit) @(posedge wb_clk_i);
        $display("watchdog expired after %0d bus cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [31:0] rdat;
        logic [31:0] val;
        string       name;
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        // Override off until a case turns it on
        drive_hsk(32'h0000_0001);
        n_checks = 0;
        load_cases();
        repeat (2) @(posedge wb_clk_i);
        #1;
        wb_rst_i = 1'b0;
        check("wb_ack_o after reset", 32'd0, 32'(wb_ack_o));
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "w": bus_access(1'b1, adr_q[i], dat_q[i], sel_q[i], rdat);
                "r": begin
                    bus_access(1'b0, adr_q[i], 32'd0, 4'hf, rdat);
                    check("wb_dat_o", exp_q[i], rdat);
                end
                "c": begin
                    bus_access(1'b0, adr_q[i], 32'd0, 4'hf, rdat);
                    check("wb_dat_o", exp_q[i], within_two(exp_q[i], rdat));
                end
                "h": drive_hsk(dat_q[i]);
                "s": mon_run[adr_q[i][1:0]] = 1'b0;
                "t": begin
                    repeat (dat_q[i]) begin
                        @(posedge wb_clk_i);
                        #1;
                    end
                end
                "o": begin
                    read_output(adr_q[i], name, val);
                    check(name, exp_q[i], val);
                end
                default: begin
                    $display("unknown opcode in case %0d", i);
                    $display("TEST FAILED");
                    $fatal(1, "bad opcode");
                end
            endcase
        end
        if (n_checks == 0) begin
            $display("no checks ran");
            $display("TEST FAILED");
            $fatal(1, "empty run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tio_hk_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tio_hk_top (
    input  wire logic        wb_clk_i,
    input  wire logic        wb_rst_i,
    // Wishbone classic target
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [11:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [3:0]  wb_sel_i,
    output logic             wb_ack_o,
    output logic [31:0]      wb_dat_o,
    // Housekeeping side
    input  wire logic        hsk_en_tri_i,
    input  wire logic        hsk_en_val_i,
    input  wire logic        hsk_local_i,
    input  wire logic        hskbus_crate_i,
    input  wire logic [7:0]  hskbus_rx_bytes_i,
    input  wire logic [1:0]  crate_conf_i,
    input  wire logic        i2c_rdy_i,
    // Clocks under watch
    input  wire logic [3:0]  mon_clk_i,
    output logic             hsk_en_o,
    output logic             sysclk_rst_o,
    output logic             enable_crate_o,
    output logic             enable_3v3_o,
    output logic [7:0]       sync_offset_o,
    output logic             en_ext_sync_o,
    output logic [7:0]       clk_offset_o,
    output logic [1:0]       burst_size_o,
    output logic [3:0]       upper_addr_o,
    output logic             sys_clk_ok_o,
    output logic             rx_clk_ok_o
);

    hk_bus_if regs_bus ();
    hk_bus_if mon_bus ();

    hk_regmap_pkg::hk_target_e tgt;
    logic        acc;
    // Monitor-relative byte address
    logic [11:0] mon_ofs;
    logic [3:0]  clk_running;
    // Ack for addresses nobody owns
    logic        none_ack_q;

    assign acc = wb_cyc_i && wb_stb_i;

    // Registers below 0x040, monitor up to 0x05F, the rest unmapped
    always_comb begin
        if (wb_adr_i < hk_regmap_pkg::HK_REGS_END) begin
            tgt = hk_regmap_pkg::HK_TGT_REGS;
        end else if (wb_adr_i < clkmon_pkg::CLKMON_OFS_END) begin
            tgt = hk_regmap_pkg::HK_TGT_CLKMON;
        end else begin
            tgt = hk_regmap_pkg::HK_TGT_NONE;
        end
    end

    assign mon_ofs = wb_adr_i - clkmon_pkg::CLKMON_OFS_BASE;

    assign regs_bus.adr  = wb_adr_i[11:2];
    assign regs_bus.wdat = wb_dat_i;
    assign regs_bus.we   = wb_we_i;
    assign regs_bus.sel  = wb_sel_i;
    assign regs_bus.req  = acc && (tgt == hk_regmap_pkg::HK_TGT_REGS);

    assign mon_bus.adr   = mon_ofs[11:2];
    assign mon_bus.wdat  = wb_dat_i;
    assign mon_bus.we    = wb_we_i;
    assign mon_bus.sel   = wb_sel_i;
    assign mon_bus.req   = acc && (tgt == hk_regmap_pkg::HK_TGT_CLKMON);

    // Same one-cycle latency as the two blocks
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= acc && (tgt == hk_regmap_pkg::HK_TGT_NONE) && !none_ack_q;
        end
    end

    // Master holds the address through ack, so the decode steers the return
    always_comb begin
        case (tgt)
            hk_regmap_pkg::HK_TGT_REGS: begin
                wb_ack_o = regs_bus.ack;
                wb_dat_o = regs_bus.rdat;
            end
            hk_regmap_pkg::HK_TGT_CLKMON: begin
                wb_ack_o = mon_bus.ack;
                wb_dat_o = mon_bus.rdat;
            end
            default: begin
                wb_ack_o = none_ack_q;
                wb_dat_o = '0;
            end
        endcase
    end

    hk_ctrl_regs u_regs (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .bus               (regs_bus.target),
        .clk_running_i     (clk_running),
        .hsk_en_tri_i      (hsk_en_tri_i),
        .hsk_en_val_i      (hsk_en_val_i),
        .hsk_local_i       (hsk_local_i),
        .hskbus_crate_i    (hskbus_crate_i),
        .hskbus_rx_bytes_i (hskbus_rx_bytes_i),
        .crate_conf_i      (crate_conf_i),
        .i2c_rdy_i         (i2c_rdy_i),
        .hsk_en_o          (hsk_en_o),
        .sysclk_rst_o      (sysclk_rst_o),
        .enable_crate_o    (enable_crate_o),
        .enable_3v3_o      (enable_3v3_o),
        .sync_offset_o     (sync_offset_o),
        .en_ext_sync_o     (en_ext_sync_o),
        .clk_offset_o      (clk_offset_o),
        .burst_size_o      (burst_size_o),
        .upper_addr_o      (upper_addr_o),
        .sys_clk_ok_o      (sys_clk_ok_o),
        .rx_clk_ok_o       (rx_clk_ok_o)
    );

    clock_mon u_mon (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .mon_clk_i     (mon_clk_i),
        .bus           (mon_bus.target),
        .clk_running_o (clk_running)
    );

endmodule

`default_nettype wire

// ==== clock_mon.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_mon (
    input  wire logic                            wb_clk_i,
    input  wire logic                            wb_rst_i,
    input  wire logic [clkmon_pkg::CLKMON_NUM-1:0] mon_clk_i,
    hk_bus_if.target                             bus,
    output logic [clkmon_pkg::CLKMON_NUM-1:0]    clk_running_o
);

    // Prescaler MSBs, one per monitored clock domain
    logic [clkmon_pkg::CLKMON_NUM-1:0] presc_msb;
    // Three-flop chain into the bus domain
    logic [clkmon_pkg::CLKMON_NUM-1:0] sync1_q;
    logic [clkmon_pkg::CLKMON_NUM-1:0] sync2_q;
    logic [clkmon_pkg::CLKMON_NUM-1:0] sync3_q;
    // One pulse per rising MSB edge
    logic [clkmon_pkg::CLKMON_NUM-1:0] rise;

    logic [$clog2(clkmon_pkg::CLKMON_WINDOW)-1:0] win_q;
    logic                                         win_end;

    logic [clkmon_pkg::CLKMON_CNT_W-1:0] cnt_q   [clkmon_pkg::CLKMON_NUM];
    logic [clkmon_pkg::CLKMON_CNT_W-1:0] cnt_nxt [clkmon_pkg::CLKMON_NUM];
    logic [clkmon_pkg::CLKMON_CNT_W-1:0] latch_q [clkmon_pkg::CLKMON_NUM];
    logic [clkmon_pkg::CLKMON_NUM-1:0]   running_q;

    // Byte offset of the access inside the monitor window
    logic [11:0] ofs;
    logic [31:0] rd_mux;

    // Each clock divides itself by 8 so the bus clock can sample it
    for (genvar g = 0; g < clkmon_pkg::CLKMON_NUM; g++) begin : g_presc
        logic [clkmon_pkg::CLKMON_PRESCALE_W-1:0] presc_q;

        // Bus reset is held for several bus cycles, long enough for a running clock
        always_ff @(posedge mon_clk_i[g]) begin
            if (wb_rst_i) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
        end

        assign presc_msb[g] = presc_q[clkmon_pkg::CLKMON_PRESCALE_W-1];
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            sync3_q <= '0;
        end else begin
            sync1_q <= presc_msb;
            sync2_q <= sync1_q;
            sync3_q <= sync2_q;
        end
    end

    assign rise    = sync2_q & ~sync3_q;
    assign win_end = (win_q == $bits(win_q)'(clkmon_pkg::CLKMON_WINDOW - 1));

    // Count including this cycle's edge, so none is lost at window end
    always_comb begin
        for (int i = 0; i < clkmon_pkg::CLKMON_NUM; i++) begin
            cnt_nxt[i] = cnt_q[i] + {{(clkmon_pkg::CLKMON_CNT_W-1){1'b0}}, rise[i]};
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            win_q     <= '0;
            running_q <= '0;
            for (int i = 0; i < clkmon_pkg::CLKMON_NUM; i++) begin
                cnt_q[i]   <= '0;
                latch_q[i] <= '0;
            end
        end else begin
            win_q <= win_end ? '0 : win_q + 1'b1;
            for (int i = 0; i < clkmon_pkg::CLKMON_NUM; i++) begin
                if (win_end) begin
                    latch_q[i]   <= cnt_nxt[i];
                    running_q[i] <= (cnt_nxt[i] != '0);
                    cnt_q[i]     <= '0;
                end else begin
                    cnt_q[i] <= cnt_nxt[i];
                end
            end
        end
    end

    // Writes land here too but change nothing
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req && !bus.ack;
        end
    end

    assign ofs = {bus.adr, 2'b00};

    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < clkmon_pkg::CLKMON_NUM; i++) begin
            if (bus.adr == ($bits(bus.adr))'(i)) begin
                rd_mux = {{(32-clkmon_pkg::CLKMON_CNT_W){1'b0}}, latch_q[i]};
            end
        end
        if (ofs == clkmon_pkg::CLKMON_OFS_RUNNING - clkmon_pkg::CLKMON_OFS_BASE) begin
            rd_mux = {{(32-clkmon_pkg::CLKMON_NUM){1'b0}}, running_q};
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus.req && !bus.ack) begin
            bus.rdat <= rd_mux;
        end
    end

    assign clk_running_o = running_q;

endmodule

`default_nettype wire

// ==== hk_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module hk_ctrl_regs (
    input  wire logic        wb_clk_i,
    input  wire logic        wb_rst_i,
    hk_bus_if.target         bus,
    // Running mask from the clock monitor
    input  wire logic [3:0]  clk_running_i,
    // Housekeeping controller override of the crate enable
    input  wire logic        hsk_en_tri_i,
    input  wire logic        hsk_en_val_i,
    input  wire logic        hsk_local_i,
    input  wire logic        hskbus_crate_i,
    input  wire logic [7:0]  hskbus_rx_bytes_i,
    input  wire logic [1:0]  crate_conf_i,
    input  wire logic        i2c_rdy_i,
    output logic             hsk_en_o,
    output logic             sysclk_rst_o,
    output logic             enable_crate_o,
    output logic             enable_3v3_o,
    output logic [7:0]       sync_offset_o,
    output logic             en_ext_sync_o,
    output logic [7:0]       clk_offset_o,
    output logic [1:0]       burst_size_o,
    output logic [3:0]       upper_addr_o,
    output logic             sys_clk_ok_o,
    output logic             rx_clk_ok_o
);

    // Byte address of the access, rebuilt from the word index
    logic [hk_regmap_pkg::HK_ADR_W-1:0] ofs;
    // Write strobe, fires on the edge that raises ack
    logic        wr;
    logic        wr_cs;
    logic        wr_sync;
    logic        wr_clkofs;
    logic        wr_bm;

    // Writable state
    logic        enable_crate_q;
    logic        enable_3v3_q;
    logic        sysclk_rst_q;
    logic [8:0]  sync_q;
    logic [7:0]  clk_offset_q;
    logic [1:0]  burst_q;
    logic [3:0]  upper_q;

    // Registered copies of slow board inputs
    logic [1:0]  crate_conf_q;
    logic        i2c_rdy_q;

    logic [31:0] ctrlstat;
    logic [31:0] boardman;
    logic [31:0] rd_mux;

    assign ofs       = {bus.adr, 2'b00};
    assign wr        = bus.req && bus.we && !bus.ack;
    assign wr_cs     = wr && (ofs == hk_regmap_pkg::HK_OFS_CTRLSTAT);
    assign wr_sync   = wr && (ofs == hk_regmap_pkg::HK_OFS_SYNC);
    assign wr_clkofs = wr && (ofs == hk_regmap_pkg::HK_OFS_CLKOFS);
    assign wr_bm     = wr && (ofs == hk_regmap_pkg::HK_OFS_BOARDMAN);

    // Ack one cycle after req, never twice in a row
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req && !bus.ack;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            enable_crate_q <= 1'b1;
            enable_3v3_q   <= 1'b1;
            sysclk_rst_q   <= 1'b1;
            sync_q         <= {1'b0, hk_regmap_pkg::HK_SYNC_OFFSET_RST};
            clk_offset_q   <= '0;
            burst_q        <= '0;
            upper_q        <= '0;
        end else begin
            // Bus write beats the housekeeping controller on the same edge
            if (wr_cs && bus.sel[0]) begin
                enable_crate_q <= bus.wdat[hk_regmap_pkg::HK_CS_ENCRATE];
            end else if (!hsk_en_tri_i) begin
                enable_crate_q <= hsk_en_val_i;
            end
            if (wr_cs && bus.sel[0]) begin
                enable_3v3_q <= bus.wdat[hk_regmap_pkg::HK_CS_EN3V3];
                sysclk_rst_q <= bus.wdat[hk_regmap_pkg::HK_CS_SYSRST];
            end
            // Offset in byte 0, enable in byte 1
            if (wr_sync && bus.sel[0]) begin
                sync_q[7:0] <= bus.wdat[7:0];
            end
            if (wr_sync && bus.sel[1]) begin
                sync_q[hk_regmap_pkg::HK_SYNC_EN] <= bus.wdat[hk_regmap_pkg::HK_SYNC_EN];
            end
            if (wr_clkofs && bus.sel[0]) begin
                clk_offset_q <= bus.wdat[7:0];
            end
            // Upper address straddles bytes 2 and 3
            if (wr_bm && bus.sel[2]) begin
                upper_q[2:0] <= bus.wdat[hk_regmap_pkg::HK_BM_UPPER +: 3];
            end
            if (wr_bm && bus.sel[3]) begin
                upper_q[3] <= bus.wdat[hk_regmap_pkg::HK_BM_UPPER + 3];
                burst_q    <= bus.wdat[hk_regmap_pkg::HK_BM_BURST +: 2];
            end
        end
    end

    // Board inputs sampled once before they reach status
    always_ff @(posedge wb_clk_i) begin
        crate_conf_q <= crate_conf_i;
        i2c_rdy_q    <= i2c_rdy_i;
    end

    always_comb begin
        ctrlstat = '0;
        ctrlstat[hk_regmap_pkg::HK_CS_SYSOK]    = sys_clk_ok_o;
        ctrlstat[hk_regmap_pkg::HK_CS_RXOK]     = rx_clk_ok_o;
        ctrlstat[hk_regmap_pkg::HK_CS_ENCRATE]  = enable_crate_q;
        ctrlstat[hk_regmap_pkg::HK_CS_EN3V3]    = enable_3v3_q;
        ctrlstat[hk_regmap_pkg::HK_CS_I2CRDY]   = i2c_rdy_q;
        ctrlstat[hk_regmap_pkg::HK_CS_HSKLOCAL] = hsk_local_i;
        ctrlstat[hk_regmap_pkg::HK_CS_HSKCRATE] = hskbus_crate_i;
        ctrlstat[hk_regmap_pkg::HK_CS_SYSRST]   = sysclk_rst_q;
        ctrlstat[hk_regmap_pkg::HK_CS_CRATECONF +: 2] = crate_conf_q;
        ctrlstat[hk_regmap_pkg::HK_CS_RXBYTES +: 8]   = hskbus_rx_bytes_i;
    end

    always_comb begin
        boardman = '0;
        boardman[hk_regmap_pkg::HK_BM_UPPER +: 4] = upper_q;
        boardman[hk_regmap_pkg::HK_BM_BURST +: 2] = burst_q;
    end

    // Reserved offsets, the DNA slot included, read zero
    always_comb begin
        case (ofs)
            hk_regmap_pkg::HK_OFS_DEVICE:   rd_mux = hk_regmap_pkg::HK_DEVICE_ID;
            hk_regmap_pkg::HK_OFS_VERSION:  rd_mux = hk_regmap_pkg::HK_VERSION;
            hk_regmap_pkg::HK_OFS_CTRLSTAT: rd_mux = ctrlstat;
            hk_regmap_pkg::HK_OFS_SYNC:     rd_mux = {23'd0, sync_q};
            hk_regmap_pkg::HK_OFS_CLKOFS:   rd_mux = {24'd0, clk_offset_q};
            hk_regmap_pkg::HK_OFS_BOARDMAN: rd_mux = boardman;
            default:                        rd_mux = '0;
        endcase
    end

    // Read data captured with ack and held until the next access
    always_ff @(posedge wb_clk_i) begin
        if (bus.req && !bus.ack) begin
            bus.rdat <= rd_mux;
        end
    end

    assign enable_crate_o = enable_crate_q;
    assign hsk_en_o       = enable_crate_q;
    assign enable_3v3_o   = enable_3v3_q;
    assign sysclk_rst_o   = sysclk_rst_q;
    assign sync_offset_o  = sync_q[7:0];
    assign en_ext_sync_o  = sync_q[hk_regmap_pkg::HK_SYNC_EN];
    assign clk_offset_o   = clk_offset_q;
    assign burst_size_o   = burst_q;
    assign upper_addr_o   = upper_q;
    assign sys_clk_ok_o   = clk_running_i[clkmon_pkg::CLKMON_IDX_SYS];
    assign rx_clk_ok_o    = clk_running_i[clkmon_pkg::CLKMON_IDX_RX];

endmodule

`default_nettype wire

// ==== hk_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One internal single-cycle access between the top-level decoder and a block
interface hk_bus_if;

    // Word index relative to the start of the target window
    logic [hk_regmap_pkg::HK_ADR_W-3:0]   adr;
    logic [hk_regmap_pkg::HK_DAT_W-1:0]   wdat;
    logic                                 we;
    // Byte enables
    logic [hk_regmap_pkg::HK_DAT_W/8-1:0] sel;
    // High while the master holds cyc and stb on this target
    logic                                 req;
    logic [hk_regmap_pkg::HK_DAT_W-1:0]   rdat;
    // One-cycle registered pulse
    logic                                 ack;

    modport host (
        output adr, wdat, we, sel, req,
        input  rdat, ack
    );

    modport target (
        input  adr, wdat, we, sel, req,
        output rdat, ack
    );

endinterface

`default_nettype wire

// ==== clkmon_pkg.sv ====
`default_nettype none

package clkmon_pkg;

    // Monitored clocks
    localparam int CLKMON_NUM = 4;

    // Each monitored clock runs a free counter of this width
    // MSB rises once every 8 monitored cycles
    localparam int CLKMON_PRESCALE_W = 3;

    // Measurement window in bus clocks
    localparam int CLKMON_WINDOW = 1024;

    // Width of a latched count
    localparam int CLKMON_CNT_W = 16;

    // Byte offsets, count n at BASE + 4n
    localparam logic [11:0] CLKMON_OFS_BASE    = 12'h040;
    localparam logic [11:0] CLKMON_OFS_RUNNING = 12'h050;
    // First address past the monitor window
    localparam logic [11:0] CLKMON_OFS_END     = 12'h060;

    // Mask bits reported as system and receive clock OK
    localparam int CLKMON_IDX_SYS = 0;
    localparam int CLKMON_IDX_RX  = 2;

endpackage

`default_nettype wire

// ==== hk_regmap_pkg.sv ====
`default_nettype none

package hk_regmap_pkg;

    // Bus geometry
    localparam int HK_ADR_W = 12;
    localparam int HK_DAT_W = 32;

    // Which block answers a decoded address
    typedef enum logic [1:0] {
        HK_TGT_REGS,
        HK_TGT_CLKMON,
        HK_TGT_NONE
    } hk_target_e;

    // Identification words
    localparam logic [HK_DAT_W-1:0] HK_DEVICE_ID = "TFIO";
    localparam logic [HK_DAT_W-1:0] HK_VERSION   = 32'h0102_0304;

    // Register byte offsets
    localparam logic [HK_ADR_W-1:0] HK_OFS_DEVICE   = 12'h000;
    localparam logic [HK_ADR_W-1:0] HK_OFS_VERSION  = 12'h004;
    localparam logic [HK_ADR_W-1:0] HK_OFS_CTRLSTAT = 12'h00C;
    localparam logic [HK_ADR_W-1:0] HK_OFS_SYNC     = 12'h010;
    localparam logic [HK_ADR_W-1:0] HK_OFS_CLKOFS   = 12'h014;
    localparam logic [HK_ADR_W-1:0] HK_OFS_BOARDMAN = 12'h018;
    // First address past the register window 0x000 to 0x03F
    localparam logic [HK_ADR_W-1:0] HK_REGS_END     = 12'h040;

    // Sync register, offset in the low byte and enable above it
    localparam logic [7:0] HK_SYNC_OFFSET_RST = 8'd8;
    localparam int         HK_SYNC_EN         = 8;

    // Control/status bit positions
    localparam int HK_CS_SYSOK     = 0;
    localparam int HK_CS_RXOK      = 1;
    localparam int HK_CS_ENCRATE   = 2;
    localparam int HK_CS_EN3V3     = 3;
    localparam int HK_CS_I2CRDY    = 4;
    localparam int HK_CS_HSKLOCAL  = 5;
    localparam int HK_CS_HSKCRATE  = 6;
    localparam int HK_CS_SYSRST    = 7;
    // Two-bit field at 9:8 and byte field at 23:16, LSB given
    localparam int HK_CS_CRATECONF = 8;
    localparam int HK_CS_RXBYTES   = 16;

    // Board-manager fields, LSB given
    // Upper address sits where a plain address would put it
    localparam int HK_BM_UPPER = 21;
    localparam int HK_BM_BURST = 30;

endpackage

`default_nettype wire
